//--- common/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;

    // Memory access size, 2'd3 is unused
    typedef enum logic [1:0]
    {
        access_byte = 2'd0,
        access_half = 2'd1,
        access_word = 2'd2
    } data_access_t;

    // Source of the register write data
    typedef enum logic [1:0]
    {
        sel_result = 2'd0,  // ALU result or address
        sel_load   = 2'd1,  // Data read from memory
        sel_link   = 2'd2   // Return address, pc + 4
    } wb_sel_t;

    typedef struct packed
    {
        inst_addr_t   pc;             // Instruction address
        data_t        result;         // ALU value or effective address
        data_t        data_b;         // Store data
        logic         mem_wr_enable;  // Store
        logic         mem_rd_enable;  // Load
        data_access_t mem_access;     // Access size
        logic         mem_unsigned;   // Zero-extend load data
        reg_addr_t    reg_wr_addr;
        logic         reg_wr_enable;
        wb_sel_t      reg_wr_sel;
    } ex_mem_t;

    // Wishbone classic request, word addressed
    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;  // Byte lane enables
        logic [29:0] adr;  // Word address
        data_t       dat;
    } wb_req_t;

    typedef struct packed
    {
        logic  ack;
        data_t dat;   // Valid together with ack
    } wb_rsp_t;

    typedef struct packed
    {
        logic      valid;
        reg_addr_t reg_addr;
        data_t     data;
    } reg_write_t;

    // One data word seen as halfword or byte lanes
    typedef union packed
    {
        logic [1:0][15:0] half_lane;
        logic [3:0][7:0]  byte_lane;
    } data_lanes_t;

endpackage

//--- logic/pipeline_ex_mem.sv
`timescale 1ns/1ps

module pipeline_ex_mem
    import rv_pkg::*;
(
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_stall,   // Hold the current instruction
    input  logic    i_flush,   // Load a bubble
    input  ex_mem_t i_ex,      // Instruction leaving EX
    output ex_mem_t o_ex_mem   // Instruction in MEM
);

    // A bubble is the all-zero word, no memory access and no register write.
    // Stall wins over flush so a pending memory access is never dropped.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_ex_mem <= '0;
        end
        else if (i_stall)
        begin
            o_ex_mem <= o_ex_mem;     // Wait for the memory access
        end
        else if (i_flush)
        begin
            o_ex_mem <= '0;
        end
        else
        begin
            o_ex_mem <= i_ex;
        end
    end

endmodule

//--- mem_stage/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
    import rv_pkg::*;
(
    input  logic    i_clock,
    input  logic    i_reset,
    input  ex_mem_t i_ex_mem,      // Instruction in MEM
    output wb_req_t o_wb_req,      // Master 0 request
    input  wb_rsp_t i_wb_rsp,      // Master 0 response
    output logic    o_busy,        // Memory access still pending
    output data_t   o_load_data    // Extended load value
);

    logic        mem_op;
    logic        done;
    logic [1:0]  offset;
    logic [3:0]  lane_sel;
    data_lanes_t store_lanes;
    data_lanes_t load_lanes;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign mem_op = i_ex_mem.mem_rd_enable || i_ex_mem.mem_wr_enable;
    assign offset = i_ex_mem.result[1:0];
    assign o_busy = mem_op && !i_wb_rsp.ack;  // Drops in the ack cycle

    // Set for the cycle after ack. The bus is released for one cycle so the
    // arbiter can rotate, and a finished access is never issued twice.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            done <= 1'b0;
        else
            done <= i_wb_rsp.ack;
    end

    // Replicate store data in every lane and enable only the addressed ones
    always_comb
    begin
        store_lanes = i_ex_mem.data_b;
        case (i_ex_mem.mem_access)
            access_byte:
            begin
                for (int i = 0; i < 4; i++)
                    store_lanes.byte_lane[i] = i_ex_mem.data_b[7:0];
                lane_sel = 4'b0001 << offset;
            end
            access_half:
            begin
                store_lanes.half_lane[0] = i_ex_mem.data_b[15:0];
                store_lanes.half_lane[1] = i_ex_mem.data_b[15:0];
                lane_sel = offset[1] ? 4'b1100 : 4'b0011;  // Aligned down
            end
            default:
                lane_sel = 4'b1111;
        endcase
    end

    always_comb
    begin
        load_lanes = i_wb_rsp.dat;
        load_byte  = load_lanes.byte_lane[offset];
        load_half  = load_lanes.half_lane[offset[1]];
        case (i_ex_mem.mem_access)
            access_byte:
                if (i_ex_mem.mem_unsigned)
                    o_load_data = {24'b0, load_byte};
                else
                    o_load_data = {{24{load_byte[7]}}, load_byte};
            access_half:
                if (i_ex_mem.mem_unsigned)
                    o_load_data = {16'b0, load_half};
                else
                    o_load_data = {{16{load_half[15]}}, load_half};
            default:
                o_load_data = i_wb_rsp.dat;
        endcase
    end

    // Request fields stay steady while EX/MEM is stalled
    always_comb
    begin
        o_wb_req.cyc = mem_op && !done;
        o_wb_req.stb = mem_op && !done;
        o_wb_req.we  = i_ex_mem.mem_wr_enable;
        o_wb_req.sel = lane_sel;
        o_wb_req.adr = i_ex_mem.result[31:2];
        o_wb_req.dat = store_lanes;
    end

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import rv_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_stall,      // Memory access pending
    input  ex_mem_t    i_ex_mem,     // Instruction in MEM
    input  data_t      i_load_data,  // Valid in the ack cycle
    output reg_write_t o_reg_write   // Register file write request
);

    data_t wr_data;

    always_comb
    begin
        case (i_ex_mem.reg_wr_sel)
            sel_load:
                wr_data = i_load_data;
            sel_link:
                wr_data = i_ex_mem.pc + 32'd4;
            default:
                wr_data = i_ex_mem.result;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_stall)
        begin
            o_reg_write <= '0;        // Bubble
        end
        else
        begin
            o_reg_write.valid    <= i_ex_mem.reg_wr_enable;
            o_reg_write.reg_addr <= i_ex_mem.reg_wr_addr;
            o_reg_write.data     <= wr_data;
        end
    end

endmodule

//--- logic/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter
    import rv_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic    i_clock,
    input  logic    i_reset,
    input  wb_req_t i_m0_req,     // Load/store unit
    input  wb_req_t i_m1_req,     // Host port
    output wb_rsp_t o_m0_rsp,
    output wb_rsp_t o_m1_rsp,
    output wb_req_t o_slave_req,
    input  wb_rsp_t i_slave_rsp
);

    logic    active;      // Grant held from the last cycle
    logic    owner;       // Master holding the grant
    logic    last;        // Master served last
    logic    hold;
    logic    pick;
    logic    sel;
    logic    sel_cyc;
    wb_req_t granted_req;

    // The owner keeps the bus while its cyc stays high. Otherwise the bus is
    // idle and a new master is picked, the one not served last on a tie.
    always_comb
    begin
        hold = active && (owner ? i_m1_req.cyc : i_m0_req.cyc);
        if (i_m0_req.cyc && i_m1_req.cyc)
            pick = ~last;
        else
            pick = i_m1_req.cyc;
        sel     = hold ? owner : pick;
        sel_cyc = sel ? i_m1_req.cyc : i_m0_req.cyc;
    end

    always_comb
    begin
        granted_req = sel ? i_m1_req : i_m0_req;
        o_slave_req = '0;           // No cyc or stb without a grant
        if (sel_cyc)
        begin
            o_slave_req     = granted_req;
            o_slave_req.adr = 30'(granted_req.adr[ADDR_WIDTH-1:0]);
        end
    end

    always_comb
    begin
        o_m0_rsp.ack = i_slave_rsp.ack && sel_cyc && !sel;
        o_m0_rsp.dat = i_slave_rsp.dat;
        o_m1_rsp.ack = i_slave_rsp.ack && sel_cyc && sel;
        o_m1_rsp.dat = i_slave_rsp.dat;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            active <= 1'b0;
            owner  <= 1'b0;
            last   <= 1'b1;         // Master 0 first
        end
        else
        begin
            active <= sel_cyc;
            owner  <= sel;
            if (i_slave_rsp.ack && sel_cyc)
                last <= sel;        // Rotate on each completed cycle
        end
    end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import rv_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic    i_clock,
    input  logic    i_reset,
    input  wb_req_t i_req,
    output wb_rsp_t o_rsp
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    data_t                 mem [DEPTH];
    data_t                 rd_data;
    logic [ADDR_WIDTH-1:0] index;
    logic                  access;
    logic                  ack;

    assign index  = i_req.adr[ADDR_WIDTH-1:0];
    assign access = i_req.cyc && i_req.stb && !ack;  // First cycle of stb only

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            ack <= 1'b0;
        else
            ack <= access;
    end

    always_ff @(posedge i_clock)
    begin
        if (access)
        begin
            if (i_req.we)
            begin
                for (int i = 0; i < 4; i++)
                    if (i_req.sel[i])
                        mem[index][i*8 +: 8] <= i_req.dat[i*8 +: 8];
            end
            rd_data <= mem[index];    // Old word on a write
        end
    end

    assign o_rsp.ack = ack;
    assign o_rsp.dat = rd_data;

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import rv_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_flush,
    input  ex_mem_t    i_ex,          // From EX
    output logic       o_stall,       // Back-pressure to EX
    output reg_write_t o_reg_write,   // To the register file
    input  wb_req_t    i_host_req,
    output wb_rsp_t    o_host_rsp
);

    ex_mem_t ex_mem;
    wb_req_t lsu_req;
    wb_rsp_t lsu_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    data_t   load_data;

    pipeline_ex_mem pipeline_ex_mem_inst (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_stall  (o_stall),
        .i_flush  (i_flush),
        .i_ex     (i_ex),
        .o_ex_mem (ex_mem)
    );

    load_store_unit load_store_unit_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_ex_mem    (ex_mem),
        .o_wb_req    (lsu_req),
        .i_wb_rsp    (lsu_rsp),
        .o_busy      (o_stall),       // Stall source for the whole pipeline
        .o_load_data (load_data)
    );

    writeback_stage writeback_stage_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_stall     (o_stall),
        .i_ex_mem    (ex_mem),
        .i_load_data (load_data),
        .o_reg_write (o_reg_write)
    );

    wb_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) wb_arbiter_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_m0_req    (lsu_req),
        .i_m1_req    (i_host_req),
        .o_m0_rsp    (lsu_rsp),
        .o_m1_rsp    (o_host_rsp),
        .o_slave_req (ram_req),
        .i_slave_rsp (ram_rsp)
    );

    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) data_ram_inst (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_req   (ram_req),
        .o_rsp   (ram_rsp)
    );

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    output logic o_clock,
    output logic o_reset
);

    initial
    begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_reset <= 1'b0;          // Released on a rising edge
    end

endmodule

//--- sim/mem_subsystem_asserts.sv
`timescale 1ns/1ps

module mem_subsystem_asserts
    import rv_pkg::*;
(
    input logic    i_clock,
    input logic    i_reset,
    input wb_req_t i_lsu_req,
    input wb_rsp_t i_lsu_rsp,
    input wb_req_t i_host_req,
    input wb_rsp_t i_host_rsp,
    input wb_rsp_t i_ram_rsp,
    input logic    i_stall
);

    localparam int STALL_LIMIT = 16;  // Well above two contended host cycles

    int stall_cycles;

    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_stall)
            stall_cycles <= 0;
        else
            stall_cycles <= stall_cycles + 1;
    end

    // Each RAM ack goes to one master only, and never gets lost
    one_ack: assert property (@(posedge i_clock) disable iff (i_reset)
        i_ram_rsp.ack |-> (i_lsu_rsp.ack != i_host_rsp.ack))
        else $error("RAM ack not routed to exactly one master");

    lsu_ack_after_stb: assert property (@(posedge i_clock) disable iff (i_reset)
        i_lsu_rsp.ack |-> $past(i_lsu_req.cyc && i_lsu_req.stb))
        else $error("Load/store unit acked without its strobe in the cycle before");

    host_ack_after_stb: assert property (@(posedge i_clock) disable iff (i_reset)
        i_host_rsp.ack |-> $past(i_host_req.cyc && i_host_req.stb))
        else $error("Host acked without its strobe in the cycle before");

    stall_bounded: assert property (@(posedge i_clock) disable iff (i_reset)
        stall_cycles < STALL_LIMIT)
        else $error("Stall held longer than %0d cycles", STALL_LIMIT);

endmodule

bind mem_subsystem mem_subsystem_asserts mem_subsystem_asserts_inst (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_lsu_req  (lsu_req),
    .i_lsu_rsp  (lsu_rsp),
    .i_host_req (i_host_req),
    .i_host_rsp (o_host_rsp),
    .i_ram_rsp  (ram_rsp),
    .i_stall    (o_stall)
);

//--- sim/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
    import rv_pkg::*;
;

    localparam int MAX_LAT    = 8;
    localparam int NUM_OPS    = 5 + 6 * 3 + 12 * 2 + 4 * 8 + 4 + 3;
    localparam int TIMEOUT_NS = (16 + NUM_OPS * MAX_LAT) * 40;

    logic       clock;
    logic       reset;
    logic       flush;
    ex_mem_t    ex;
    logic       stall;
    reg_write_t wb_out;
    wb_req_t    host_req;
    wb_rsp_t    host_rsp;

    data_t       ref_mem [1024];  // Expected RAM contents
    int          errors = 0;
    int          test_errors = 0;
    int          stall_seen;      // Instructions that stalled
    logic [31:0] lcg_state = 32'd51147;

    clock_gen clock_gen_inst (.o_clock(clock), .o_reset(reset));

    mem_subsystem #(
        .ADDR_WIDTH (10)
    ) mem_subsystem_inst (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_flush     (flush),
        .i_ex        (ex),
        .o_stall     (stall),
        .o_reg_write (wb_out),
        .i_host_req  (host_req),
        .o_host_rsp  (host_rsp)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Word after a store of the given size at the given byte offset
    function automatic data_t store_merge(data_t old, data_t val, logic [1:0] off,
                                          data_access_t size);
        data_t mask;
        int    sh;
        case (size)
            access_byte:
            begin
                sh   = 32'(off) * 8;
                mask = 32'hff << sh;
            end
            access_half:
            begin
                sh   = 32'(off[1]) * 16;
                mask = 32'hffff << sh;
            end
            default:
            begin
                sh   = 0;
                mask = 32'hffffffff;
            end
        endcase
        return (old & ~mask) | ((val << sh) & mask);
    endfunction

    function automatic data_t load_extend(data_t word, logic [1:0] off,
                                          data_access_t size, logic uns);
        data_t v;
        case (size)
            access_byte:
            begin
                v = (word >> (32'(off) * 8)) & 32'hff;
                if (!uns && v[7])
                    v = v | 32'hffffff00;
            end
            access_half:
            begin
                v = (word >> (32'(off[1]) * 16)) & 32'hffff;
                if (!uns && v[15])
                    v = v | 32'hffff0000;
            end
            default:
                v = word;
        endcase
        return v;
    endfunction

    function automatic ex_mem_t make_instr(logic wr, logic rd, logic [9:0] wadr,
                                           logic [1:0] off, data_t data_b,
                                           data_access_t size, logic uns,
                                           reg_addr_t rd_addr, wb_sel_t sel);
        ex_mem_t i;
        i               = '0;
        i.pc            = next_rand() & 32'hfffffffc;
        i.result        = wr || rd ? {20'b0, wadr, off} : next_rand();
        i.data_b        = data_b;
        i.mem_wr_enable = wr;
        i.mem_rd_enable = rd;
        i.mem_access    = size;
        i.mem_unsigned  = uns;
        i.reg_wr_addr   = rd_addr;
        i.reg_wr_enable = !wr;
        i.reg_wr_sel    = sel;
        return i;
    endfunction

    // Register write expected from an instruction that is not a load
    function automatic data_t alu_value(ex_mem_t i);
        return i.reg_wr_sel == sel_link ? i.pc + 32'd4 : i.result;
    endfunction

    task automatic check_value(string name, data_t got, data_t exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_wb(ex_mem_t i, data_t exp);
        check_value("o_reg_write.valid", 32'(wb_out.valid), 32'(1));
        check_value("o_reg_write.reg_addr", 32'(wb_out.reg_addr), 32'(i.reg_wr_addr));
        check_value("o_reg_write.data", wb_out.data, exp);
    endtask

    task automatic host_access(logic we, logic [9:0] adr, data_t dat);
        wb_req_t r;
        int      cnt;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.sel = 4'hf;
        r.adr = 30'(adr);
        r.dat = dat;
        cnt   = 0;
        @(posedge clock);
        host_req <= r;
        do
        begin
            @(negedge clock);
            cnt++;
        end
        while (!host_rsp.ack && cnt < 4 * MAX_LAT);
        assert (host_rsp.ack)
        else
        begin
            $display("Host access to word %h was never acknowledged", adr);
            test_errors++;
        end
        if (we)
            ref_mem[adr] = dat;
        else
            check_value("o_host_rsp.dat", host_rsp.dat, ref_mem[adr]);
        @(posedge clock);
        host_req <= '0;
    endtask

    // Issue one instruction, wait for the stall to clear, check the writeback
    task automatic run_instr(ex_mem_t i, logic expect_wb, data_t exp);
        int   cnt;
        logic stalled;
        cnt     = 0;
        stalled = 1'b0;
        @(posedge clock);
        ex <= i;
        @(posedge clock);
        ex <= '0;
        do
        begin
            @(negedge clock);
            cnt++;
            if (stall)
                stalled = 1'b1;
        end
        while (stall && cnt < 4 * MAX_LAT);
        if (stalled)
            stall_seen++;
        assert (!stall)
        else
        begin
            $display("Stall never dropped for the instruction at pc %h", i.pc);
            test_errors++;
        end
        @(negedge clock);
        if (expect_wb)
            check_wb(i, exp);
        else
            check_value("o_reg_write.valid", 32'(wb_out.valid), 32'(0));
    endtask

    task automatic end_test(string name);
        $display("Test %-11s %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_alu();
        ex_mem_t i;
        for (int n = 0; n < 5; n++)
        begin
            i = make_instr(0, 0, '0, '0, '0, access_word, 0, 5'(n + 1),
                           n == 4 ? sel_link : sel_result);
            run_instr(i, 1, alu_value(i));
        end
        end_test("alu");
    endtask

    task automatic test_stores();
        logic [9:0]   adr;
        logic [1:0]   off;
        data_t        val;
        data_access_t size;
        for (int n = 0; n < 6; n++)
        begin
            adr  = 10'(next_rand() >> 8);
            off  = 2'(next_rand() >> 4);
            size = data_access_t'(2'(n % 3));
            val  = next_rand();
            host_access(1, adr, next_rand());
            run_instr(make_instr(1, 0, adr, off, val, size, 0, '0, sel_result), 0, '0);
            ref_mem[adr] = store_merge(ref_mem[adr], val, off, size);
            host_access(0, adr, '0);
        end
        end_test("stores");
    endtask

    task automatic test_loads();
        logic [9:0]   adr;
        logic [1:0]   off;
        data_access_t size;
        logic         uns;
        for (int n = 0; n < 12; n++)
        begin
            adr  = 10'(next_rand() >> 8);
            off  = 2'(next_rand() >> 4);
            size = data_access_t'(2'(n % 3));
            uns  = n >= 6;
            if (n % 2 == 1)
                host_access(1, adr, next_rand() | 32'h80808080);  // Negative lanes
            else
                host_access(1, adr, next_rand() & 32'h7f7f7f7f);  // Positive lanes
            run_instr(make_instr(0, 1, adr, off, '0, size, uns, 5'(n + 1), sel_load), 1,
                      load_extend(ref_mem[adr], off, size, uns));
        end
        end_test("loads");
    endtask

    task automatic test_contention();
        logic [9:0] ld_adr [8];
        logic [9:0] hw_adr [8];
        data_t      hw_dat [8];
        for (int n = 0; n < 8; n++)
        begin
            ld_adr[n] = {1'b0, 9'(next_rand() >> 8)};
            hw_adr[n] = {1'b1, 9'(next_rand() >> 8)};  // Upper half only
            hw_dat[n] = next_rand();
            host_access(1, ld_adr[n], next_rand());
        end
        stall_seen = 0;
        fork
            for (int n = 0; n < 8; n++)
                host_access(1, hw_adr[n], hw_dat[n]);
            for (int n = 0; n < 8; n++)
                run_instr(make_instr(0, 1, ld_adr[n], '0, '0, access_word, 0, 5'(n + 1),
                                     sel_load), 1, ref_mem[ld_adr[n]]);
        join
        assert (stall_seen == 8)
        else
        begin
            $display("Stall did not rise for every load under contention");
            test_errors++;
        end
        for (int n = 0; n < 8; n++)
            host_access(0, hw_adr[n], '0);
        end_test("contention");
    endtask

    task automatic test_flush();
        logic [9:0] adr;
        adr = 10'(next_rand() >> 8);
        host_access(1, adr, next_rand());
        @(posedge clock);
        ex    <= make_instr(1, 0, adr, '0, next_rand(), access_word, 0, '0, sel_result);
        flush <= 1'b1;
        @(posedge clock);
        ex    <= make_instr(0, 0, '0, '0, '0, access_word, 0, 5'd7, sel_result);
        @(posedge clock);
        ex    <= '0;
        flush <= 1'b0;
        repeat (4)
        begin
            @(negedge clock);
            check_value("o_reg_write.valid", 32'(wb_out.valid), 32'(0));
        end
        host_access(0, adr, '0);
        end_test("flush");
    endtask

    task automatic test_stall_hold();
        logic [9:0] adr;
        ex_mem_t    ld;
        ex_mem_t    alu;
        int         cnt;
        adr = 10'(next_rand() >> 8);
        cnt = 0;
        host_access(1, adr, next_rand());
        ld  = make_instr(0, 1, adr, '0, '0, access_word, 0, 5'd3, sel_load);
        alu = make_instr(0, 0, '0, '0, '0, access_word, 0, 5'd9, sel_result);
        @(posedge clock);
        ex <= ld;
        @(posedge clock);
        ex <= alu;                // Arrives while the load stalls
        do
        begin
            @(negedge clock);
            cnt++;
        end
        while (stall && cnt < 4 * MAX_LAT);
        @(posedge clock);
        ex <= '0;
        @(negedge clock);
        check_wb(ld, ref_mem[adr]);
        @(negedge clock);
        check_wb(alu, alu_value(alu));
        end_test("stall_hold");
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        ex       = '0;
        flush    = 1'b0;
        host_req = '0;
        do
            @(posedge clock);
        while (reset !== 1'b0);
        test_alu();
        test_stores();
        test_loads();
        test_contention();
        test_flush();
        test_stall_hold();
        $display("6 tests run, %0d errors", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- mem_subsystem.f
common/rv_pkg.sv
logic/pipeline_ex_mem.sv
mem_stage/load_store_unit.sv
logic/writeback_stage.sv
logic/wb_arbiter.sv
logic/data_ram.sv
logic/mem_subsystem.sv
sim/clock_gen.sv
sim/mem_subsystem_asserts.sv
sim/mem_subsystem_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f mem_subsystem.f \
		--top-module mem_subsystem_tb -o mem_subsystem_sim
	./obj_dir/mem_subsystem_sim | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
